// File: logic/ahb_sram_defines.svh
// Memory map and SRAM sizing for the AHB-Lite memory subsystem
// Included by the package and by any RTL that needs the raw numbers
// Each SRAM region is 4 KB and decodes on the address bits above AWIDTH

`ifndef AHB_SRAM_DEFINES_SVH
`define AHB_SRAM_DEFINES_SVH

// ------------------------------
// SRAM geometry
// ------------------------------
// Byte address width of one SRAM
`define AHB_SRAM_AWIDTH 12
// Depth in 32-bit words, must equal 2**(AWIDTH-2)
`define AHB_SRAM_WORDS 1024

// ------------------------------
// Region bases
// ------------------------------
`define AHB_CODE_BASE 32'h0000_0000
`define AHB_DATA_BASE 32'h2000_0000

`endif

// File: logic/ahb_sram_pkg.sv
// Shared types for the AHB-Lite memory subsystem
// AHB encodings, the address-phase request bundle, the SRAM port bundle
// and the slave slot names used by the decoder and testbench

`include "ahb_sram_defines.svh"

package ahb_sram_pkg;

   // ------------------------------
   // AHB encodings
   // ------------------------------
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   // Only the three sizes a 32-bit bus can carry
   typedef enum logic [2:0] {
      BYTE = 3'b000,
      HALF = 3'b001,
      WORD = 3'b010
   } hsize_e;

   typedef enum logic {
      OKAY  = 1'b0,
      ERROR = 1'b1
   } hresp_e;

   // Address-phase signals from the master
   typedef struct packed {
      logic [31:0] haddr;
      htrans_e     htrans;
      logic        hwrite;
      hsize_e      hsize;
      logic [2:0]  hburst;   // carried, not used
      logic [3:0]  hprot;    // carried, not used
      logic        hmastlock;
   } ahb_req_t;

   // Bridge to SRAM strobes, word addressed
   typedef struct packed {
      logic                          cs;
      logic [3:0]                    we;
      logic [`AHB_SRAM_AWIDTH-3:0]   ad;
      logic [31:0]                   wd;
   } sram_req_t;

   // Which slave owns a transfer
   typedef enum logic [1:0] {
      SLOT_CODE = 2'd0,
      SLOT_DATA = 2'd1,
      SLOT_NONE = 2'd2
   } slot_e;

   // Default slave FSM
   typedef enum logic {
      DS_IDLE = 1'b0,
      DS_ERR  = 1'b1
   } dslv_state_e;

endpackage

// File: logic/ahb_sram_bridge.sv
// Zero-wait-state AHB-Lite to synchronous SRAM bridge
// Writes are held in a one-entry buffer so a following read can take
// the SRAM in its address phase; the buffer drains on the next free cycle
// Reads that hit the pending word get the buffered bytes merged in
// One instance per SRAM, selected by the address decoder

`timescale 1ns/1ps

`include "ahb_sram_defines.svh"

module ahb_sram_bridge (
   input  logic                    HCLK,
   input  logic                    HRESETn,
   input  ahb_sram_pkg::ahb_req_t  ahb_req,
   input  logic                    hsel,
   input  logic                    hready,
   input  logic [31:0]             hwdata,
   output logic [31:0]             hrdata,
   output ahb_sram_pkg::sram_req_t ram,
   input  logic [31:0]             ramrd
);

   import ahb_sram_pkg::*;

   localparam int AW = `AHB_SRAM_AWIDTH;

   // ------------------------------
   // Buffer state
   // ------------------------------
   // Pending byte enables, nonzero while a write waits for the SRAM
   logic [3:0]    buf_we_q;
   logic [AW-3:0] buf_waddr_q;
   logic [31:0]   buf_wdata_q;
   // Set once HWDATA has been parked in buf_wdata_q
   logic          buf_wdata_v_q;
   // Read address matched the pending word
   logic          buf_hit_q;

   logic          ahb_access;
   logic          ahb_write;
   logic          ahb_read;
   logic          ram_write;
   logic          buf_wdata_en;
   logic [3:0]    byte_sels;
   logic [3:0]    merge;
   logic [AW-3:0] haddr_word;

   // ------------------------------
   // Transfer qualification
   // ------------------------------
   assign ahb_access = hsel && hready && (ahb_req.htrans inside {NONSEQ, SEQ});
   assign ahb_write  = ahb_access &&  ahb_req.hwrite;
   assign ahb_read   = ahb_access && !ahb_req.hwrite;
   assign haddr_word = ahb_req.haddr[AW-1:2];

   // A read always wins the SRAM, the pending write waits
   assign ram_write  = (|buf_we_q) && !ahb_read;

   // Park HWDATA when the write data phase loses the SRAM to a read
   assign buf_wdata_en = (|buf_we_q) && ahb_read && !buf_wdata_v_q;

   // Byte lanes from size and low address bits
   always_comb begin
      case (ahb_req.hsize)
         BYTE:    byte_sels = 4'b0001 << ahb_req.haddr[1:0];
         HALF:    byte_sels = ahb_req.haddr[1] ? 4'b1100 : 4'b0011;
         default: byte_sels = 4'b1111;
      endcase
   end

   // ------------------------------
   // Control registers
   // ------------------------------
   // Loaded on a write address phase, cleared when the buffer drains
   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         buf_we_q <= 4'b0000;
      end else if (ahb_write || ram_write) begin
         buf_we_q <= ahb_write ? byte_sels : 4'b0000;
      end
   end

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         buf_wdata_v_q <= 1'b0;
      end else if (buf_wdata_en || ram_write) begin
         buf_wdata_v_q <= buf_wdata_en;
      end
   end

   // ------------------------------
   // Payload registers
   // ------------------------------
   always_ff @(posedge HCLK) begin
      if (ahb_write) begin
         buf_waddr_q <= haddr_word;
      end
   end

   // Only the enabled lanes are stored
   always_ff @(posedge HCLK) begin
      for (int b = 0; b < 4; b++) begin
         if (buf_wdata_en && buf_we_q[b]) begin
            buf_wdata_q[8*b +: 8] <= hwdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge HCLK) begin
      if (ahb_read) begin
         buf_hit_q <= (haddr_word == buf_waddr_q);
      end
   end

   // ------------------------------
   // Read data merge
   // ------------------------------
   // Pending lanes of a hit come from the buffer, the rest from the SRAM
   assign merge = {4{buf_hit_q}} & buf_we_q;

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         hrdata[8*b +: 8] = merge[b] ? buf_wdata_q[8*b +: 8] : ramrd[8*b +: 8];
      end
   end

   // ------------------------------
   // SRAM port
   // ------------------------------
   always_comb begin
      ram.cs = ahb_read || ram_write;
      // No byte enables on a read
      ram.we = {4{ram_write}} & buf_we_q;
      ram.ad = ahb_read ? haddr_word : buf_waddr_q;
      // Live HWDATA when the write lands in its own data phase
      ram.wd = buf_wdata_v_q ? buf_wdata_q : hwdata;
   end

endmodule

// File: logic/sram_sp.sv
// Single-port synchronous SRAM model
// Byte write enables, one-cycle registered read data on every select
// Write cycles return the old word on ramrd

`timescale 1ns/1ps

`include "ahb_sram_defines.svh"

module sram_sp (
   input  logic                    HCLK,
   input  ahb_sram_pkg::sram_req_t ram,
   output logic [31:0]             ramrd
);

   // ------------------------------
   // Storage
   // ------------------------------
   logic [31:0] mem [0:`AHB_SRAM_WORDS-1];

   // Per-lane writes under cs
   always_ff @(posedge HCLK) begin
      if (ram.cs) begin
         for (int b = 0; b < 4; b++) begin
            if (ram.we[b]) begin
               mem[ram.ad][8*b +: 8] <= ram.wd[8*b +: 8];
            end
         end
      end
   end

   // ------------------------------
   // Read port
   // ------------------------------
   // Data appears the cycle after the select
   always_ff @(posedge HCLK) begin
      if (ram.cs) begin
         ramrd <= mem[ram.ad];
      end
   end

endmodule

// File: logic/ahb_addr_decoder.sv
// AHB-Lite address decoder and slave response multiplexer
// Address phase decodes HADDR into one select per slave
// The slot of each accepted active transfer is registered and steers
// read data, ready and response back to the master in the data phase

`timescale 1ns/1ps

`include "ahb_sram_defines.svh"

module ahb_addr_decoder (
   input  logic                   HCLK,
   input  logic                   HRESETn,
   input  ahb_sram_pkg::ahb_req_t ahb_req,
   input  logic                   hready,
   output logic                   sel_code,
   output logic                   sel_data,
   output logic                   sel_none,
   input  logic [31:0]            rdata_code,
   input  logic [31:0]            rdata_data,
   input  logic                   dslv_ready,
   input  ahb_sram_pkg::hresp_e   dslv_resp,
   output logic [31:0]            hrdata,
   output logic                   hready_out,
   output ahb_sram_pkg::hresp_e   hresp
);

   import ahb_sram_pkg::*;

   localparam int          AW        = `AHB_SRAM_AWIDTH;
   localparam logic [31:0] CODE_BASE = `AHB_CODE_BASE;
   localparam logic [31:0] DATA_BASE = `AHB_DATA_BASE;

   slot_e addr_slot;
   slot_e dslot_q;
   logic  dphase_q;
   logic  active;

   // ------------------------------
   // Address phase decode
   // ------------------------------
   // Region match on the bits above the SRAM size
   assign sel_code = (ahb_req.haddr[31:AW] == CODE_BASE[31:AW]);
   assign sel_data = (ahb_req.haddr[31:AW] == DATA_BASE[31:AW]);
   assign sel_none = !sel_code && !sel_data;

   assign addr_slot = sel_code ? SLOT_CODE : (sel_data ? SLOT_DATA : SLOT_NONE);
   assign active    = ahb_req.htrans inside {NONSEQ, SEQ};

   // ------------------------------
   // Data phase slot
   // ------------------------------
   // Advances only when the bus moves on
   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         dslot_q  <= SLOT_NONE;
         dphase_q <= 1'b0;
      end else if (hready) begin
         dslot_q  <= active ? addr_slot : SLOT_NONE;
         dphase_q <= active;
      end
   end

   // ------------------------------
   // Response mux
   // ------------------------------
   // SRAM slots never stall or fail
   always_comb begin
      hrdata     = '0;
      hready_out = 1'b1;
      hresp      = OKAY;
      if (dphase_q) begin
         case (dslot_q)
            SLOT_CODE: hrdata = rdata_code;
            SLOT_DATA: hrdata = rdata_data;
            default: begin
               // Default slave owns ready and response
               hready_out = dslv_ready;
               hresp      = dslv_resp;
            end
         endcase
      end
   end

endmodule

// File: logic/ahb_default_slave.sv
// AHB-Lite default slave for unmapped addresses
// Every active transfer selected here gets the two-cycle ERROR response
// IDLE and BUSY transfers see a zero-wait OKAY

`timescale 1ns/1ps

module ahb_default_slave (
   input  logic                   HCLK,
   input  logic                   HRESETn,
   input  logic                   hsel,
   input  ahb_sram_pkg::ahb_req_t ahb_req,
   input  logic                   hready,
   output logic                   hreadyout,
   output ahb_sram_pkg::hresp_e   hresp
);

   import ahb_sram_pkg::*;

   dslv_state_e state_q;
   dslv_state_e state_nxt;
   // Second ERROR cycle, ready back high
   logic        err_tail_q;
   logic        access;

   assign access = hsel && hready && (ahb_req.htrans inside {NONSEQ, SEQ});

   // ------------------------------
   // FSM
   // ------------------------------
   always_comb begin
      state_nxt = state_q;
      case (state_q)
         DS_IDLE: if (access) state_nxt = DS_ERR;
         // Only one stalled cycle
         default: state_nxt = DS_IDLE;
      endcase
   end

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         state_q    <= DS_IDLE;
         err_tail_q <= 1'b0;
      end else begin
         state_q    <= state_nxt;
         err_tail_q <= (state_q == DS_ERR);
      end
   end

   // ------------------------------
   // Response
   // ------------------------------
   assign hreadyout = (state_q != DS_ERR);
   assign hresp     = ((state_q == DS_ERR) || err_tail_q) ? ERROR : OKAY;

endmodule

// File: logic/ahb_sram_subsys.sv
// AHB-Lite memory subsystem top level
// One master port fans out to a code SRAM, a data SRAM and a default slave
// The decoder selects the slave and returns the data-phase response,
// whose ready is fed back as HREADY to every slave
// Code region at 0x0000_0000, data region at 0x2000_0000, 4 KB each

`timescale 1ns/1ps

module ahb_sram_subsys (
   input  logic                   HCLK,
   input  logic                   HRESETn,
   input  ahb_sram_pkg::ahb_req_t ahb_req,
   input  logic [31:0]            hwdata,
   output logic [31:0]            hrdata,
   output logic                   hready,
   output ahb_sram_pkg::hresp_e   hresp
);

   import ahb_sram_pkg::*;

   // ------------------------------
   // Interconnect
   // ------------------------------
   logic        sel_code;
   logic        sel_data;
   logic        sel_none;
   logic [31:0] rdata_code;
   logic [31:0] rdata_data;
   logic        dslv_ready;
   hresp_e      dslv_resp;

   sram_req_t   ram_code;
   sram_req_t   ram_data;
   logic [31:0] ramrd_code;
   logic [31:0] ramrd_data;

   // Select decode and response mux
   ahb_addr_decoder u_decoder (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .ahb_req    (ahb_req),
      .hready     (hready),
      .sel_code   (sel_code),
      .sel_data   (sel_data),
      .sel_none   (sel_none),
      .rdata_code (rdata_code),
      .rdata_data (rdata_data),
      .dslv_ready (dslv_ready),
      .dslv_resp  (dslv_resp),
      .hrdata     (hrdata),
      .hready_out (hready),
      .hresp      (hresp)
   );

   // ------------------------------
   // Code SRAM
   // ------------------------------
   ahb_sram_bridge u_code_bridge (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .ahb_req (ahb_req),
      .hsel    (sel_code),
      .hready  (hready),
      .hwdata  (hwdata),
      .hrdata  (rdata_code),
      .ram     (ram_code),
      .ramrd   (ramrd_code)
   );

   sram_sp u_code_ram (
      .HCLK  (HCLK),
      .ram   (ram_code),
      .ramrd (ramrd_code)
   );

   // ------------------------------
   // Data SRAM
   // ------------------------------
   ahb_sram_bridge u_data_bridge (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .ahb_req (ahb_req),
      .hsel    (sel_data),
      .hready  (hready),
      .hwdata  (hwdata),
      .hrdata  (rdata_data),
      .ram     (ram_data),
      .ramrd   (ramrd_data)
   );

   sram_sp u_data_ram (
      .HCLK  (HCLK),
      .ram   (ram_data),
      .ramrd (ramrd_data)
   );

   // Catches everything outside both regions
   ahb_default_slave u_dslv (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .hsel      (sel_none),
      .ahb_req   (ahb_req),
      .hready    (hready),
      .hreadyout (dslv_ready),
      .hresp     (dslv_resp)
   );

endmodule

// File: bench/tb_ahb_sram.sv
// Trace-driven testbench for the AHB-Lite memory subsystem
// Loads transfers from bench/ahb_sram_trace.txt and plays them as a pipelined
// AHB-Lite master, one address phase per line
// Read data, response and wait states are checked in each data phase
// Run from the project root with compile.f, top module tb_ahb_sram

`timescale 1ns/1ps

module tb_ahb_sram;

   import ahb_sram_pkg::*;

   localparam int MAX_LINES = 256;

   typedef enum logic [1:0] {
      OP_IDLE,
      OP_WRITE,
      OP_READ
   } op_e;

   logic        HCLK;
   logic        HRESETn;
   ahb_req_t    ahb_req;
   logic [31:0] hwdata;
   logic [31:0] hrdata;
   logic        hready;
   hresp_e      hresp;

   // ------------------------------
   // Trace storage
   // ------------------------------
   op_e         tr_op    [0:MAX_LINES-1];
   logic [2:0]  tr_size  [0:MAX_LINES-1];
   logic [31:0] tr_addr  [0:MAX_LINES-1];
   logic [31:0] tr_wdata [0:MAX_LINES-1];
   logic [31:0] tr_rdata [0:MAX_LINES-1];
   hresp_e      tr_resp  [0:MAX_LINES-1];

   int     n_lines;
   bit     loaded;
   integer seed;
   int     data_errs;
   int     resp_errs;
   int     ready_errs;
   int     other_errs;

   ahb_sram_subsys u_dut (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .ahb_req (ahb_req),
      .hwdata  (hwdata),
      .hrdata  (hrdata),
      .hready  (hready),
      .hresp   (hresp)
   );

   // 100 MHz
   initial HCLK = 1'b0;
   always #5 HCLK = ~HCLK;

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_data(input int k, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         data_errs++;
         $display("Fail at %0t ns: hrdata expected %08h, got %08h (trace line %0d)",
                  $time, exp, act, k);
      end
   endtask

   task automatic check_resp(input int k, input hresp_e exp, input hresp_e act);
      if (act !== exp) begin
         resp_errs++;
         $display("Fail at %0t ns: hresp expected %s, got %s (%b) (trace line %0d)",
                  $time, exp.name(), act.name(), act, k);
      end
   endtask

   task automatic check_ready(input int k, input logic exp, input logic act);
      if (act !== exp) begin
         ready_errs++;
         $display("Fail at %0t ns: hready expected %b, got %b (trace line %0d)",
                  $time, exp, act, k);
      end
   endtask

   // ------------------------------
   // Trace loading
   // ------------------------------
   // Lines that do not parse as six fields are comments or blank
   task automatic load_trace();
      int             fd;
      int             cnt;
      int             size_v;
      int             resp_v;
      logic [1023:0]  text_line;
      logic [63:0]    op_str;
      logic [31:0]    addr_v;
      logic [31:0]    wdata_v;
      logic [31:0]    rdata_v;
      n_lines = 0;
      fd = $fopen("bench/ahb_sram_trace.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("Error: the trace file bench/ahb_sram_trace.txt could not be opened");
      end else begin
         while (!$feof(fd) && n_lines < MAX_LINES) begin
            text_line = '0;
            op_str    = '0;
            if ($fgets(text_line, fd) == 0) break;
            cnt = $sscanf(text_line, "%s %d %h %h %h %d",
                          op_str, size_v, addr_v, wdata_v, rdata_v, resp_v);
            if (cnt == 6) begin
               if (op_str == "write") tr_op[n_lines] = OP_WRITE;
               else if (op_str == "read") tr_op[n_lines] = OP_READ;
               else if (op_str == "idle") tr_op[n_lines] = OP_IDLE;
               else begin
                  other_errs++;
                  $display("Error: unknown operation on trace entry %0d", n_lines);
               end
               tr_size[n_lines]  = size_v[2:0];
               tr_addr[n_lines]  = addr_v;
               tr_wdata[n_lines] = wdata_v;
               tr_rdata[n_lines] = rdata_v;
               tr_resp[n_lines]  = (resp_v != 0) ? ERROR : OKAY;
               n_lines++;
            end
         end
         $fclose(fd);
         if (n_lines == 0) begin
            other_errs++;
            $display("Error: the trace file holds no transfers");
         end
      end
   endtask

   // ------------------------------
   // Bus driving
   // ------------------------------
   // Index past the end gives an IDLE that closes the last data phase
   task automatic drive_addr(input int i);
      logic [31:0] rnd;
      rnd = $random(seed);
      ahb_req.hburst    = rnd[2:0];
      ahb_req.hprot     = rnd[6:3];
      ahb_req.hmastlock = 1'b0;
      if (i >= n_lines) begin
         ahb_req.haddr  = '0;
         ahb_req.htrans = IDLE;
         ahb_req.hwrite = 1'b0;
         ahb_req.hsize  = WORD;
      end else begin
         ahb_req.haddr  = tr_addr[i];
         ahb_req.hsize  = hsize_e'(tr_size[i]);
         // Idle lines keep hwrite high and the slaves must still ignore them
         ahb_req.hwrite = (tr_op[i] != OP_READ);
         ahb_req.htrans = (tr_op[i] == OP_IDLE) ? IDLE : NONSEQ;
      end
   endtask

   // Samples mid-cycle until hready is high while the address phase is held
   task automatic finish_data_phase(input int k);
      int   cyc;
      logic exp_ready;
      bit   done;
      cyc  = 0;
      done = 1'b0;
      while (!done) begin
         @(negedge HCLK);
         if (k >= 0) begin
            check_resp(k, tr_resp[k], hresp);
            // An ERROR response stalls only its first data-phase cycle
            exp_ready = !((tr_resp[k] == ERROR) && (cyc == 0));
            check_ready(k, exp_ready, hready);
         end
         if (hready) begin
            done = 1'b1;
         end
         cyc++;
      end
      // Read data only means something on an OKAY read
      if (k >= 0 && tr_op[k] == OP_READ && tr_resp[k] == OKAY) begin
         check_data(k, tr_rdata[k], hrdata);
      end
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial begin
      int total;
      seed       = 32'h54407fc6;
      data_errs  = 0;
      resp_errs  = 0;
      ready_errs = 0;
      other_errs = 0;
      loaded     = 1'b0;
      HRESETn    = 1'b0;
      ahb_req    = '0;
      hwdata     = '0;
      load_trace();
      loaded = 1'b1;
      repeat (2) @(posedge HCLK);
      #1;
      HRESETn = 1'b1;
      // Line i address phase overlaps line i-1 data phase
      for (int i = 0; i <= n_lines; i++) begin
         @(posedge HCLK);
         #1;
         drive_addr(i);
         hwdata = (i > 0) ? tr_wdata[i-1] : 32'h0;
         finish_data_phase(i - 1);
      end
      total = data_errs + resp_errs + ready_errs + other_errs;
      $display("Summary: %0d transfers, %0d data, %0d response, %0d ready, %0d other errors",
               n_lines, data_errs, resp_errs, ready_errs, other_errs);
      if (total == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Watchdog sized from the trace length
   initial begin
      wait (loaded);
      repeat (n_lines * 3 + 20) @(posedge HCLK);
      $display("Error: timeout, the trace did not complete within %0d cycles",
               n_lines * 3 + 20);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: compile.f
+incdir+logic
logic/ahb_sram_pkg.sv
logic/ahb_sram_bridge.sv
logic/sram_sp.sv
logic/ahb_addr_decoder.sv
logic/ahb_default_slave.sv
logic/ahb_sram_subsys.sv
bench/tb_ahb_sram.sv

// File: bench/ahb_sram_trace.txt
# op size addr wdata exp_rdata exp_resp; size 0 byte 1 half 2 word; resp 0 OKAY 1 ERROR
# addr and data in hex; wdata goes out in the data phase; exp_rdata is checked on reads only
write 2 00000010 11223344 00000000 0
write 2 20000020 a5a5f00d 00000000 0
idle  2 00000000 00000000 00000000 0
read  2 00000010 00000000 11223344 0
read  2 20000020 00000000 a5a5f00d 0
write 2 20000040 00000000 00000000 0
write 0 20000040 66666612 00000000 0
write 0 20000043 cd555555 00000000 0
read  2 20000040 00000000 cd000012 0
write 2 00000080 00000000 00000000 0
write 1 00000082 9abc7777 00000000 0
write 1 00000080 88885678 00000000 0
write 0 00000081 1111ee11 00000000 0
idle  2 00000080 ffffffff 00000000 0
read  2 00000080 00000000 9abcee78 0
write 2 20000100 deadbeef 00000000 0
read  2 20000040 00000000 cd000012 0
read  2 20000100 00000000 deadbeef 0
idle  2 20000100 00000000 00000000 0
read  2 20000100 00000000 deadbeef 0
read  2 10000000 00000000 00000000 1
read  2 00000010 00000000 11223344 0
write 2 00001000 12345678 00000000 1
write 2 00000200 01010101 00000000 0
read  2 00000200 00000000 01010101 0
write 2 20000200 03030303 00000000 0
read  2 00000080 00000000 9abcee78 0
write 2 00000204 02020202 00000000 0
read  2 20000200 00000000 03030303 0
read  2 00000204 00000000 02020202 0
idle  2 20000020 ffffffff 00000000 0
idle  2 10000000 00000000 00000000 0
read  2 20000020 00000000 a5a5f00d 0
read  2 00000200 00000000 01010101 0
